/* compile.f */
+incdir+.
memPkg.sv
memStageReg.sv
storeLaneSplit.sv
dataByteLane.sv
loadMerge.sv
memAccessStage.sv
tb_memAccessStage.sv

/* dataByteLane.sv */
module dataByteLane import memPkg::*; (
    input  logic                  clk,
    input  logic                  we,
    input  logic [WORD_IDX_W-1:0] idx,
    input  logic [BYTE_W-1:0]     wrData,
    output logic [BYTE_W-1:0]     rdData
);

    logic [BYTE_W-1:0] mem [WORDS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= wrData;
        end
        rdData <= mem[idx];   // old contents on a same-edge write
    end

    // an X index would smear the write over unknown entries
    assert property (@(posedge clk) we |-> !$isunknown(idx))
        else $error("lane write with unknown index");

endmodule

/* loadMerge.sv */
module loadMerge import memPkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  issue,
    input  logic [DATA_W-1:0]     memAddr,
    input  loadKind               memLoadKind,
    input  logic [REG_IDX_W-1:0]  memDst,
    input  logic [DATA_W-1:0]     memPc,
    input  excKind                excCode,
    input  logic [DATA_W-1:0]     laneRdData,

    output logic                  resultValid,
    output logic [DATA_W-1:0]     result,
    output logic [REG_IDX_W-1:0]  resultDst,
    output logic                  resultWr,
    output logic                  excValid,
    output excKind                excCodeOut,
    output logic [DATA_W-1:0]     excPc,
    output logic [DATA_W-1:0]     badVAddr
);

    logic                 capValid;
    loadKind              capLoadKind;
    logic [REG_IDX_W-1:0] capDst;
    logic [DATA_W-1:0]    capPc;
    logic [DATA_W-1:0]    capAddr;
    excKind               capExc;

    logic [1:0]           capOffset;
    logic [BYTE_W-1:0]    rdByte;
    logic [2*BYTE_W-1:0]  rdHalf;
    logic [DATA_W-1:0]    merged;
    logic                 capFault;

    always_ff @(posedge clk) begin
        if (rst) begin
            capValid <= 1'b0;
        end else begin
            capValid <= issue;   // lines up with the lane read
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            capLoadKind <= memLoadKind;
            capDst      <= memDst;
            capPc       <= memPc;
            capAddr     <= memAddr;
            capExc      <= excCode;
        end
    end

    assign capOffset = capAddr[1:0];
    assign capFault  = capExc != EXC_NONE;

    // little-endian pick out of the four lanes
    assign rdByte = laneRdData[capOffset*BYTE_W +: BYTE_W];
    assign rdHalf = capOffset[1] ? laneRdData[DATA_W-1:2*BYTE_W] : laneRdData[2*BYTE_W-1:0];

    always_comb begin
        case (capLoadKind)
            LD_B:    merged = {{(DATA_W-BYTE_W){rdByte[BYTE_W-1]}}, rdByte};
            LD_BU:   merged = {{(DATA_W-BYTE_W){1'b0}}, rdByte};
            LD_H:    merged = {{(DATA_W-2*BYTE_W){rdHalf[2*BYTE_W-1]}}, rdHalf};
            LD_HU:   merged = {{(DATA_W-2*BYTE_W){1'b0}}, rdHalf};
            LD_W:    merged = laneRdData;
            default: merged = '0;   // stores return nothing
        endcase
    end

    assign resultValid = capValid;
    assign result      = merged;
    assign resultDst   = capDst;
    assign resultWr    = capValid && (capLoadKind != LD_NONE) && !capFault;

    // address error report
    assign excValid   = capValid && capFault;
    assign excCodeOut = capExc;
    assign excPc      = capPc;
    assign badVAddr   = capAddr;

    // a register write never comes out of an empty or faulting slot
    assert property (@(posedge clk) disable iff (rst) resultWr |-> resultValid && !excValid)
        else $error("resultWr without a clean valid result");

endmodule

/* memAccessStage.sv */
module memAccessStage import memPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,
    input  logic                 hold,

    input  logic                 exeValid,
    input  logic [DATA_W-1:0]    exeAddr,
    input  logic [DATA_W-1:0]    exeStoreData,
    input  loadKind              exeLoadKind,
    input  storeKind             exeStoreKind,
    input  logic [REG_IDX_W-1:0] exeDst,
    input  logic [DATA_W-1:0]    exePc,

    output logic                 resultValid,
    output logic [DATA_W-1:0]    result,
    output logic [REG_IDX_W-1:0] resultDst,
    output logic                 resultWr,
    output logic                 excValid,
    output excKind               excCodeOut,
    output logic [DATA_W-1:0]    excPc,
    output logic [DATA_W-1:0]    badVAddr
);

    // stage register outputs
    logic                  issue;
    logic [DATA_W-1:0]     memAddr;
    logic [DATA_W-1:0]     memStoreData;
    loadKind               memLoadKind;
    storeKind              memStoreKind;
    logic [REG_IDX_W-1:0]  memDst;
    logic [DATA_W-1:0]     memPc;

    // lane side
    logic [LANES-1:0]      laneWe;
    logic [DATA_W-1:0]     laneWrData;
    logic [DATA_W-1:0]     laneRdData;
    logic [WORD_IDX_W-1:0] wordIdx;
    excKind                excCode;

    memStageReg uStageReg (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .hold         (hold),
        .exeValid     (exeValid),
        .exeAddr      (exeAddr),
        .exeStoreData (exeStoreData),
        .exeLoadKind  (exeLoadKind),
        .exeStoreKind (exeStoreKind),
        .exeDst       (exeDst),
        .exePc        (exePc),
        .issue        (issue),
        .memAddr      (memAddr),
        .memStoreData (memStoreData),
        .memLoadKind  (memLoadKind),
        .memStoreKind (memStoreKind),
        .memDst       (memDst),
        .memPc        (memPc)
    );

    storeLaneSplit uLaneSplit (
        .issue        (issue),
        .memAddr      (memAddr),
        .memStoreData (memStoreData),
        .memLoadKind  (memLoadKind),
        .memStoreKind (memStoreKind),
        .laneWe       (laneWe),
        .laneWrData   (laneWrData),
        .wordIdx      (wordIdx),
        .excCode      (excCode)
    );

    // lane k holds address byte k
    for (genvar k = 0; k < LANES; k++) begin : gLane
        dataByteLane uLane (
            .clk    (clk),
            .we     (laneWe[k]),
            .idx    (wordIdx),
            .wrData (laneWrData[k*BYTE_W +: BYTE_W]),
            .rdData (laneRdData[k*BYTE_W +: BYTE_W])
        );
    end

    loadMerge uLoadMerge (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .memAddr     (memAddr),
        .memLoadKind (memLoadKind),
        .memDst      (memDst),
        .memPc       (memPc),
        .excCode     (excCode),
        .laneRdData  (laneRdData),
        .resultValid (resultValid),
        .result      (result),
        .resultDst   (resultDst),
        .resultWr    (resultWr),
        .excValid    (excValid),
        .excCodeOut  (excCodeOut),
        .excPc       (excPc),
        .badVAddr    (badVAddr)
    );

endmodule

/* memPkg.sv */
package memPkg;

    // datapath geometry
    localparam int DATA_W     = 32;
    localparam int LANES      = 4;
    localparam int BYTE_W     = DATA_W / LANES;   // width of one lane
    localparam int WORD_IDX_W = 8;
    localparam int WORDS      = 1 << WORD_IDX_W;  // 256 words, 1 KiB total
    localparam int REG_IDX_W  = 5;

    // load opcodes, U variants zero-extend
    typedef enum logic [2:0] {
        LD_NONE,
        LD_B,
        LD_BU,
        LD_H,
        LD_HU,
        LD_W
    } loadKind;

    // store opcodes
    typedef enum logic [1:0] {
        ST_NONE,
        ST_B,
        ST_H,
        ST_W
    } storeKind;

    // address error causes
    typedef enum logic [1:0] {
        EXC_NONE,
        EXC_ADEL,   // misaligned load
        EXC_ADES    // misaligned store
    } excKind;

endpackage

/* memStageReg.sv */
module memStageReg import memPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,
    input  logic                 hold,

    input  logic                 exeValid,
    input  logic [DATA_W-1:0]    exeAddr,
    input  logic [DATA_W-1:0]    exeStoreData,
    input  loadKind              exeLoadKind,
    input  storeKind             exeStoreKind,
    input  logic [REG_IDX_W-1:0] exeDst,
    input  logic [DATA_W-1:0]    exePc,

    output logic                 issue,
    output logic [DATA_W-1:0]    memAddr,
    output logic [DATA_W-1:0]    memStoreData,
    output loadKind              memLoadKind,
    output storeKind             memStoreKind,
    output logic [REG_IDX_W-1:0] memDst,
    output logic [DATA_W-1:0]    memPc
);

    logic memValid;   // an instruction sits in the stage

    // control part, flush beats hold
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            memValid     <= 1'b0;
            memLoadKind  <= LD_NONE;
            memStoreKind <= ST_NONE;
        end else if (!hold) begin
            memValid     <= exeValid;
            memLoadKind  <= exeLoadKind;
            memStoreKind <= exeStoreKind;
        end
    end

    // payload only follows hold
    always_ff @(posedge clk) begin
        if (!hold) begin
            memAddr      <= exeAddr;
            memStoreData <= exeStoreData;
            memDst       <= exeDst;
            memPc        <= exePc;
        end
    end

    // leaves the register this cycle, once
    assign issue = memValid && !hold;

    // a flushed slot must come back empty, whatever hold does
    assert property (@(posedge clk) disable iff (rst) flush |=> !issue)
        else $error("issue raised in the cycle after a flush");

endmodule

/* storeLaneSplit.sv */
module storeLaneSplit import memPkg::*; (
    input  logic                  issue,
    input  logic [DATA_W-1:0]     memAddr,
    input  logic [DATA_W-1:0]     memStoreData,
    input  loadKind               memLoadKind,
    input  storeKind              memStoreKind,

    output logic [LANES-1:0]      laneWe,
    output logic [DATA_W-1:0]     laneWrData,
    output logic [WORD_IDX_W-1:0] wordIdx,
    output excKind                excCode
);

    logic [1:0]       offset;
    logic             halfAcc;
    logic             wordAcc;
    logic             misaligned;
    logic [LANES-1:0] laneMask;   // lanes touched by the store

    assign offset  = memAddr[1:0];
    assign wordIdx = memAddr[WORD_IDX_W+1:2];   // upper bits alias

    // access size from whichever kind is active
    assign halfAcc = (memLoadKind == LD_H) || (memLoadKind == LD_HU) ||
                     (memStoreKind == ST_H);
    assign wordAcc = (memLoadKind == LD_W) || (memStoreKind == ST_W);

    // half needs offset 0 or 2 and word needs offset 0
    assign misaligned = (halfAcc && offset[0]) || (wordAcc && (offset != 2'b00));

    always_comb begin
        if (!misaligned) begin
            excCode = EXC_NONE;
        end else if (memStoreKind != ST_NONE) begin
            excCode = EXC_ADES;
        end else begin
            excCode = EXC_ADEL;
        end
    end

    // replicate store data so every lane sees its byte
    always_comb begin
        case (memStoreKind)
            ST_B: begin
                laneWrData = {LANES{memStoreData[BYTE_W-1:0]}};
                laneMask   = 4'b0001 << offset;
            end
            ST_H: begin
                laneWrData = {(LANES/2){memStoreData[2*BYTE_W-1:0]}};
                laneMask   = 4'b0011 << offset;
            end
            ST_W: begin
                laneWrData = memStoreData;
                laneMask   = '1;
            end
            default: begin
                laneWrData = memStoreData;
                laneMask   = '0;   // loads write nothing
            end
        endcase
    end

    // writes only for an issuing, well-aligned store
    assign laneWe = (issue && (excCode == EXC_NONE)) ? laneMask : '0;

    // a misaligned store must leave memory untouched
    always_comb begin
        assert final (!(((memStoreKind == ST_H) && memAddr[0]) ||
                        ((memStoreKind == ST_W) && (memAddr[1:0] != 2'b00))) ||
                      (laneWe == '0))
            else $error("lane write enabled on a misaligned store");
    end

endmodule

/* memModel.svh */
`ifndef MEM_MODEL_SVH
`define MEM_MODEL_SVH

// byte image of the data memory
logic [BYTE_W-1:0] refMem [WORDS*LANES];

// applies one access to the image and gives what the stage should return
function automatic void refAccess(
    input  logic [DATA_W-1:0] addr,
    input  logic [DATA_W-1:0] wrData,
    input  loadKind           lk,
    input  storeKind          sk,
    output logic [DATA_W-1:0] expResult,
    output logic              expWr,
    output excKind            expExc
);
    int unsigned       base;
    logic [1:0]        off;
    int                sizeB;
    logic              misal;
    logic [DATA_W-1:0] word;

    base  = {addr[WORD_IDX_W+1:2], 2'b00};   // aliased like the lanes
    off   = addr[1:0];
    sizeB = 1;   // access size in bytes
    if (lk == LD_H || lk == LD_HU || sk == ST_H) begin
        sizeB = 2;
    end
    if (lk == LD_W || sk == ST_W) begin
        sizeB = 4;
    end
    misal = (int'(off) % sizeB) != 0;   // natural alignment
    expResult = '0;
    expWr     = 1'b0;

    if (misal) begin
        expExc = (sk != ST_NONE) ? EXC_ADES : EXC_ADEL;
        return;   // memory left alone
    end
    expExc = EXC_NONE;

    case (sk)
        ST_B: refMem[base+off] = wrData[7:0];
        ST_H: begin
            refMem[base+off]   = wrData[7:0];
            refMem[base+off+1] = wrData[15:8];
        end
        ST_W: for (int k = 0; k < LANES; k++) refMem[base+k] = wrData[k*BYTE_W +: BYTE_W];
        default: ;
    endcase

    word = {refMem[base+3], refMem[base+2], refMem[base+1], refMem[base]};
    case (lk)
        LD_B:  expResult = {{24{word[off*8+7]}}, word[off*8 +: 8]};
        LD_BU: expResult = {24'd0, word[off*8 +: 8]};
        LD_H:  expResult = {{16{word[off*8+15]}}, word[off*8 +: 16]};
        LD_HU: expResult = {16'd0, word[off*8 +: 16]};
        LD_W:  expResult = word;
        default: ;
    endcase
    expWr = (lk != LD_NONE);
endfunction

`endif

/* tb_memAccessStage.sv */
module tb_memAccessStage import memPkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 8;
    localparam int STIM_DLY   = 5;
    localparam int OP_COUNT   = 128 + 32 + 11 + 24 + 200;   // sum over the five tests

    logic                 clk;
    logic                 rst;
    logic                 flush;
    logic                 hold;
    logic                 exeValid;
    logic [DATA_W-1:0]    exeAddr;
    logic [DATA_W-1:0]    exeStoreData;
    loadKind              exeLoadKind;
    storeKind             exeStoreKind;
    logic [REG_IDX_W-1:0] exeDst;
    logic [DATA_W-1:0]    exePc;

    logic                 resultValid;
    logic [DATA_W-1:0]    result;
    logic [REG_IDX_W-1:0] resultDst;
    logic                 resultWr;
    logic                 excValid;
    excKind               excCodeOut;
    logic [DATA_W-1:0]    excPc;
    logic [DATA_W-1:0]    badVAddr;

    typedef struct packed {
        logic [DATA_W-1:0]    res;
        logic                 wr;
        excKind               exc;
        logic [REG_IDX_W-1:0] dst;
        logic [DATA_W-1:0]    pc;
        logic [DATA_W-1:0]    addr;
    } expEntry;

    expEntry expQ[$];   // one entry per issued instruction, in issue order

    // shadow of the stage register, follows the driven inputs only
    logic                 shValid;
    logic [DATA_W-1:0]    shAddr;
    logic [DATA_W-1:0]    shData;
    loadKind              shLk;
    storeKind             shSk;
    logic [REG_IDX_W-1:0] shDst;
    logic [DATA_W-1:0]    shPc;

    integer      seed = 32'h04d844a6;
    logic [31:0] pcNext;
    logic        chaos;   // random hold and flush while sending
    int          errCount;
    int          errMark;
    int          checkCount;
    int          testsRun;
    int          testsFailed;

    `include "memModel.svh"

    memAccessStage i_dut (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .hold         (hold),
        .exeValid     (exeValid),
        .exeAddr      (exeAddr),
        .exeStoreData (exeStoreData),
        .exeLoadKind  (exeLoadKind),
        .exeStoreKind (exeStoreKind),
        .exeDst       (exeDst),
        .exePc        (exePc),
        .resultValid  (resultValid),
        .result       (result),
        .resultDst    (resultDst),
        .resultWr     (resultWr),
        .excValid     (excValid),
        .excCodeOut   (excCodeOut),
        .excPc        (excPc),
        .badVAddr     (badVAddr)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    task automatic reportMismatch(input string sig, input logic [31:0] expVal,
                                  input logic [31:0] actVal);
        errCount++;
        $display("** Error at time %0t: %s expected %h actual %h", $time, sig, expVal, actVal);
    endtask

    // issue tracking, the model sees accesses in the order the stage issues them
    always @(posedge clk) begin
        logic [DATA_W-1:0] r;
        logic              w;
        excKind            x;
        if (!rst && shValid && !hold) begin
            refAccess(shAddr, shData, shLk, shSk, r, w, x);
            expQ.push_back('{res: r, wr: w, exc: x, dst: shDst, pc: shPc, addr: shAddr});
        end
        if (rst || flush) begin
            shValid = 1'b0;   // flush wins over hold
        end else if (!hold) begin
            shValid = exeValid;
            shAddr  = exeAddr;
            shData  = exeStoreData;
            shLk    = exeLoadKind;
            shSk    = exeStoreKind;
            shDst   = exeDst;
            shPc    = exePc;
        end
    end

    // compare at the falling edge where outputs are settled
    always @(negedge clk) begin
        expEntry e;
        if (!rst && (resultValid || excValid)) begin
            if (expQ.size() == 0) begin
                errCount++;
                $display("result at time %0t with no issued instruction left to match", $time);
            end else begin
                e = expQ.pop_front();
                checkCount++;
                if (resultValid !== 1'b1) reportMismatch("resultValid", 1, resultValid);
                if (resultWr !== e.wr) reportMismatch("resultWr", e.wr, resultWr);
                if (excValid !== (e.exc != EXC_NONE)) begin
                    reportMismatch("excValid", e.exc != EXC_NONE, excValid);
                end
                if (e.exc != EXC_NONE) begin
                    if (excCodeOut !== e.exc) reportMismatch("excCodeOut", e.exc, excCodeOut);
                    if (excPc !== e.pc) reportMismatch("excPc", e.pc, excPc);
                    if (badVAddr !== e.addr) reportMismatch("badVAddr", e.addr, badVAddr);
                end
                if (e.wr) begin
                    if (result !== e.res) reportMismatch("result", e.res, result);
                    if (resultDst !== e.dst) reportMismatch("resultDst", e.dst, resultDst);
                end
            end
        end
    end

    task automatic idle();
        exeValid     = 1'b0;
        exeLoadKind  = LD_NONE;
        exeStoreKind = ST_NONE;
        hold         = 1'b0;
        flush        = 1'b0;
    endtask

    // keeps the instruction on the inputs until the stage takes or drops it
    task automatic sendOp(input logic [31:0] addr, input logic [31:0] data, input loadKind lk,
                          input storeKind sk, input logic [REG_IDX_W-1:0] dst);
        logic taken;
        taken        = 1'b0;
        exeValid     = 1'b1;
        exeAddr      = addr;
        exeStoreData = data;
        exeLoadKind  = lk;
        exeStoreKind = sk;
        exeDst       = dst;
        exePc        = pcNext;
        pcNext       = pcNext + 4;
        while (!taken) begin
            if (chaos) begin
                hold  = (rnd() & 3) == 0;
                flush = (rnd() & 15) == 0;
            end
            taken = !hold || flush;   // flush drops it
            @(posedge clk);
            #STIM_DLY;
        end
        idle();
    endtask

    task automatic drain();
        int waitCycles;
        waitCycles = 0;
        idle();
        while ((expQ.size() != 0 || shValid) && waitCycles < 8) begin
            @(posedge clk);
            #STIM_DLY;
            waitCycles++;
        end
        if (expQ.size() != 0 || shValid) begin
            errCount++;
            $display("pipeline did not drain, %0d results never appeared", expQ.size());
        end
    endtask

    task automatic finishTest(input string name);
        int fails;
        drain();
        fails = errCount - errMark;
        errMark = errCount;
        testsRun++;
        if (fails != 0) testsFailed++;
        $display("test %-14s %s with %0d errors", name, (fails != 0) ? "failed" : "ok", fails);
    endtask

    task automatic wordFillTest();
        for (int i = 0; i < 64; i++) sendOp(i * 4, rnd(), LD_NONE, ST_W, 0);
        for (int i = 0; i < 64; i++) sendOp(i * 4, 0, LD_W, ST_NONE, 5'(i));
        finishTest("word fill");
    endtask

    task automatic subWordTest();
        logic [31:0] base;
        base = 32'h200;
        for (int off = 0; off < 4; off++) sendOp(base + off, rnd(), LD_NONE, ST_B, 0);
        sendOp(base + 4, rnd(), LD_NONE, ST_H, 0);
        sendOp(base + 6, rnd(), LD_NONE, ST_H, 0);
        for (int w = 0; w < 2; w++) begin
            for (int off = 0; off < 4; off++) begin
                sendOp(base + w * 4 + off, 0, LD_B, ST_NONE, 5'(off + 1));
                sendOp(base + w * 4 + off, 0, LD_BU, ST_NONE, 5'(off + 5));
                if (off % 2 == 0) begin
                    sendOp(base + w * 4 + off, 0, LD_H, ST_NONE, 5'(off + 9));
                    sendOp(base + w * 4 + off, 0, LD_HU, ST_NONE, 5'(off + 13));
                end
            end
            sendOp(base + w * 4, 0, LD_W, ST_NONE, 5'd20);
        end
        finishTest("sub-word");
    endtask

    task automatic misalignTest();
        logic [31:0] base;
        base = 32'h0C0;   // word 48, filled by the first test
        for (int off = 1; off < 4; off++) begin
            sendOp(base + off, 0, LD_W, ST_NONE, 5'd3);
            sendOp(base + off, rnd(), LD_NONE, ST_W, 0);
        end
        sendOp(base + 1, 0, LD_H, ST_NONE, 5'd3);
        sendOp(base + 3, 0, LD_HU, ST_NONE, 5'd3);
        sendOp(base + 1, rnd(), LD_NONE, ST_H, 0);
        sendOp(base + 3, rnd(), LD_NONE, ST_H, 0);
        sendOp(base, 0, LD_W, ST_NONE, 5'd4);   // memory must be unchanged
        finishTest("misaligned");
    endtask

    task automatic rawHazardTest();
        logic [31:0] a;
        logic [31:0] addr;
        for (int i = 0; i < 8; i++) begin
            a = rnd();
            addr = {a[31:10], 2'b00, 6'(i * 7 + 1), 2'b00};   // high bits alias
            sendOp(addr, rnd(), LD_NONE, ST_W, 0);
            sendOp(addr, 0, LD_W, ST_NONE, 5'(i + 10));
        end
        for (int j = 0; j < 4; j++) begin
            sendOp(32'h0A0 + j, rnd(), LD_NONE, ST_B, 0);
            sendOp(32'h0A0 + j, 0, LD_B, ST_NONE, 5'(j + 20));
        end
        finishTest("store-load");
    endtask

    task automatic stallFlushTest();
        logic [31:0] a;
        logic [31:0] addr;
        chaos = 1'b1;
        for (int i = 0; i < 200; i++) begin
            a = rnd();
            addr = {a[31:10], 2'b00, a[7:0]};   // stay in the filled words
            case (rnd() & 7)
                0: sendOp(addr, rnd(), LD_NONE, ST_W, 0);
                1: sendOp(addr, rnd(), LD_NONE, ST_H, 0);
                2: sendOp(addr, rnd(), LD_NONE, ST_B, 0);
                3: sendOp(addr, 0, LD_W, ST_NONE, a[14:10]);
                4: sendOp(addr, 0, LD_H, ST_NONE, a[14:10]);
                5: sendOp(addr, 0, LD_HU, ST_NONE, a[14:10]);
                6: sendOp(addr, 0, LD_B, ST_NONE, a[14:10]);
                default: sendOp(addr, 0, LD_BU, ST_NONE, a[14:10]);
            endcase
        end
        chaos = 1'b0;
        finishTest("hold-flush");
    endtask

    // watchdog, four cycles per instruction is ample even with stalls
    initial begin
        #(OP_COUNT * CLK_PERIOD * 4 + RST_CYCLES * CLK_PERIOD);
        $display("watchdog expired before all tests completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        rst          = 1'b1;
        exeAddr      = '0;
        exeStoreData = '0;
        exeDst       = '0;
        exePc        = '0;
        idle();
        chaos        = 1'b0;
        pcNext       = 32'hBFC0_0000;
        errCount     = 0;
        errMark      = 0;
        checkCount   = 0;
        testsRun     = 0;
        testsFailed  = 0;
        repeat (RST_CYCLES) @(posedge clk);
        #STIM_DLY;
        rst = 1'b0;

        wordFillTest();
        subWordTest();
        misalignTest();
        rawHazardTest();
        stallFlushTest();

        $display("tests %0d, failed %0d, results checked %0d, errors %0d",
                 testsRun, testsFailed, checkCount, errCount);
        if (errCount == 0 && testsFailed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
